//--- list.f
+incdir+logic
logic/z80BusPkg.sv
logic/tStateSequencer.sv
logic/busStrobeGen.sv
logic/dmaBlockMover.sv
logic/busArbiter.sv
logic/z80BusSubsystem.sv
verification/busMemoryModel.sv
verification/z80BusSubsystemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the Z80 bus unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    -f list.f --top-module z80BusSubsystemTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vz80BusSubsystemTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi

//--- verification/z80BusSubsystemTb.sv
// Testbench top that runs host and DMA traffic through the Z80 bus unit against a shadow model
`default_nettype none

module z80BusSubsystemTb;

    timeunit 1ns;
    timeprecision 100ps;

    import z80BusPkg::*;

    // Phase A has 32 host transactions, phase B 24, and one read waits out the DMA
    localparam int HOST_XFERS  = 57;
    localparam int DMA_BYTES   = 16;
    localparam int CYCLE_LIMIT = 40 * (HOST_XFERS + DMA_BYTES);

    logic        CLK_n = 1'b0;
    logic        Reset_s;
    logic        reqValid_i;
    cycleKind_t  reqKind_i;
    busAddr_t    reqAddr_i;
    busData_t    reqWrData_i;
    logic        reqReady_o;
    logic        rspValid_o;
    busData_t    rspData_o;
    logic        dmaStart_i;
    busAddr_t    dmaSrc_i;
    busAddr_t    dmaDst_i;
    dmaLen_t     dmaLen_i;
    logic        dmaBusy_o;
    logic        waitLine;
    busData_t    busToDut;
    busAddr_t    a_o;
    busData_t    d_o;
    logic        m1N_o;
    logic        mreqN_o;
    logic        iorqN_o;
    logic        rdN_o;
    logic        wrN_o;
    logic        rfshN_o;
    logic        busakN_o;
    logic        waitEnable;
    logic [31:0] waitCount;
    logic        protoErr;

    busData_t    shadowMem [0:65535];
    busData_t    shadowIo [0:255];
    logic [31:0] randState;
    int          cycleCount = 0;
    cycleKind_t  activeKind = memRead;
    logic        prevRfshN = 1'b1;
    logic        rfshSeen = 1'b0;
    rfshCount_t  lastRow;
    logic        dmaOwned = 1'b0;
    logic        busakLowSeen = 1'b0;

    z80BusSubsystem UUT (
        .CLK_n(CLK_n), .Reset_s(Reset_s),
        .reqValid_i(reqValid_i), .reqKind_i(reqKind_i),
        .reqAddr_i(reqAddr_i), .reqWrData_i(reqWrData_i),
        .reqReady_o(reqReady_o), .rspValid_o(rspValid_o), .rspData_o(rspData_o),
        .dmaStart_i(dmaStart_i), .dmaSrc_i(dmaSrc_i), .dmaDst_i(dmaDst_i),
        .dmaLen_i(dmaLen_i), .dmaBusy_o(dmaBusy_o),
        .wait_i(waitLine), .d_i(busToDut), .a_o(a_o), .d_o(d_o),
        .m1N_o(m1N_o), .mreqN_o(mreqN_o), .iorqN_o(iorqN_o), .rdN_o(rdN_o),
        .wrN_o(wrN_o), .rfshN_o(rfshN_o), .busakN_o(busakN_o)
    );

    busMemoryModel memModel (
        .CLK_n(CLK_n), .Reset_s(Reset_s), .waitEnable_i(waitEnable),
        .a_i(a_o), .d_i(d_o), .mreqN_i(mreqN_o), .iorqN_i(iorqN_o),
        .rdN_i(rdN_o), .wrN_i(wrN_o), .rfshN_i(rfshN_o),
        .wait_o(waitLine), .d_o(busToDut), .waitCount_o(waitCount), .protoErr_o(protoErr)
    );

    always #5 CLK_n = ~CLK_n;

    function automatic logic [31:0] randNext();
        randState = randState * 32'd1103515245 + 32'd12345;
        return randState;
    endfunction

    // Bus cycles from T1 to the last T-state without waits
    function automatic int nominalCycles(input cycleKind_t kind);
        case (kind)
            fetch:   return 4;
            ioRead:  return 4;
            ioWrite: return 4;
            default: return 3;
        endcase
    endfunction

    // I/O ports decode only the low address byte
    function automatic busData_t expectedRead(input cycleKind_t kind, input busAddr_t addr);
        if (kind == ioRead) begin
            return shadowIo[addr[7:0]];
        end
        return shadowMem[addr];
    endfunction

    task automatic checkData(input string name, input busData_t got, input busData_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic checkAddr(input string name, input busAddr_t got, input busAddr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic checkStrobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    // Runs one host transaction and checks its latency and read data
    task automatic hostXfer(input cycleKind_t kind, input busAddr_t addr, input busData_t wrData);
        int          latency;
        logic [31:0] waitsBefore;
        reqValid_i  <= 1'b1;
        reqKind_i   <= kind;
        reqAddr_i   <= addr;
        reqWrData_i <= wrData;
        @(posedge CLK_n);
        while (!reqReady_o) begin
            @(posedge CLK_n);
        end
        activeKind = kind;
        waitsBefore = waitCount;
        reqValid_i <= 1'b0;
        latency = 0;
        do begin
            @(posedge CLK_n);
            latency++;
        end while (!rspValid_o);
        checkCount("host latency", latency,
                   nominalCycles(kind) + 1 + int'(waitCount - waitsBefore));
        if (kind == memWrite) begin
            shadowMem[addr] = wrData;
        end else if (kind == ioWrite) begin
            shadowIo[addr[7:0]] = wrData;
        end else begin
            checkData("rspData_o", rspData_o, expectedRead(kind, addr));
        end
        // Cycles outside a host transaction belong to the DMA, which never fetches
        activeKind = memRead;
    endtask

    // Refresh row and M1 are checked at the falling edge where the strobes are settled
    always @(negedge CLK_n) begin
        if (!rdN_o && !mreqN_o) begin
            checkStrobe("rfshN_o", rfshN_o, 1'b1);
            checkStrobe("m1N_o", m1N_o, activeKind != fetch);
        end
        if (Reset_s && prevRfshN && !rfshN_o) begin
            if (rfshSeen) begin
                checkAddr("a_o refresh", a_o, busAddr_t'(rfshCount_t'(lastRow + 1'b1)));
            end
            rfshSeen <= 1'b1;
            lastRow  <= a_o[6:0];
        end
        prevRfshN <= rfshN_o;
    end

    // The DMA holds the bus for the whole block once it has taken it
    always @(posedge CLK_n) begin
        cycleCount <= cycleCount + 1;
        checkStrobe("protocol error", protoErr, 1'b0);
        if (dmaBusy_o) begin
            checkStrobe("reqReady_o", reqReady_o, 1'b0);
            checkStrobe("rspValid_o", rspValid_o, 1'b0);
            if (dmaOwned) begin
                checkStrobe("busakN_o", busakN_o, 1'b0);
            end
            if (!busakN_o) begin
                busakLowSeen <= 1'b1;
            end
        end
        dmaOwned <= dmaBusy_o && (dmaOwned || !busakN_o);
        if (cycleCount > CYCLE_LIMIT) begin
            $display("The run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [31:0] r;
        busAddr_t    src;
        busAddr_t    dst;
        Reset_s     = 1'b0;
        reqValid_i  = 1'b0;
        reqKind_i   = memRead;
        reqAddr_i   = '0;
        reqWrData_i = '0;
        dmaStart_i  = 1'b0;
        dmaSrc_i    = '0;
        dmaDst_i    = '0;
        dmaLen_i    = '0;
        waitEnable  = 1'b0;
        randState   = 32'h8b4c;
        for (int i = 0; i < 65536; i++) begin
            shadowMem[i] = busData_t'(i) ^ busData_t'(i >> 8) ^ 8'h5a;
        end
        for (int i = 0; i < 256; i++) begin
            shadowIo[i] = ~busData_t'(i) ^ 8'h3c;
        end
        repeat (4) @(posedge CLK_n);
        Reset_s <= 1'b1;

        // Idle bus after reset
        repeat (3) begin
            @(posedge CLK_n);
            checkStrobe("mreqN_o", mreqN_o, 1'b1);
            checkStrobe("iorqN_o", iorqN_o, 1'b1);
            checkStrobe("rdN_o", rdN_o, 1'b1);
            checkStrobe("wrN_o", wrN_o, 1'b1);
            checkStrobe("m1N_o", m1N_o, 1'b1);
            checkStrobe("rfshN_o", rfshN_o, 1'b1);
            checkStrobe("busakN_o", busakN_o, 1'b1);
            checkStrobe("rspValid_o", rspValid_o, 1'b0);
            checkStrobe("reqReady_o", reqReady_o, 1'b0);
            checkStrobe("dmaBusy_o", dmaBusy_o, 1'b0);
        end

        // No waits, so every latency is the nominal count plus one
        for (int i = 0; i < 8; i++) begin
            hostXfer(memWrite, busAddr_t'(16'h2000 + i * 16'h0125), busData_t'(randNext() >> 16));
        end
        for (int i = 0; i < 8; i++) begin
            hostXfer(memRead, busAddr_t'(16'h2000 + i * 16'h0125), 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            hostXfer(fetch, busAddr_t'(16'h0100 + i), 8'h00);
        end
        for (int i = 0; i < 4; i++) begin
            hostXfer(ioWrite, busAddr_t'(16'h0040 + i * 3), busData_t'(randNext() >> 16));
        end
        for (int i = 0; i < 4; i++) begin
            hostXfer(ioRead, busAddr_t'(16'h0040 + i * 3), 8'h00);
        end
        // Same numbers as memory addresses must still hold the fill pattern
        for (int i = 0; i < 4; i++) begin
            hostXfer(memRead, busAddr_t'(16'h0040 + i * 3), 8'h00);
        end

        // Random kinds and random wait states in a small window
        waitEnable <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            r = randNext();
            hostXfer(cycleKind_t'(int'(r[18:16]) % 5), {8'h30, r[7:0]}, r[31:24]);
        end

        // The overlapping block move is copied byte by byte as the engine does
        src = 16'h3000;
        dst = 16'h3008;
        dmaStart_i <= 1'b1;
        dmaSrc_i   <= src;
        dmaDst_i   <= dst;
        dmaLen_i   <= dmaLen_t'(DMA_BYTES);
        @(posedge CLK_n);
        dmaStart_i <= 1'b0;
        while (!dmaBusy_o) begin
            @(posedge CLK_n);
        end
        for (int i = 0; i < DMA_BYTES; i++) begin
            shadowMem[busAddr_t'(dst + i)] = shadowMem[busAddr_t'(src + i)];
        end
        hostXfer(memRead, dst, 8'h00);
        checkStrobe("busakN_o low during DMA", busakLowSeen, 1'b1);
        for (int i = 0; i < DMA_BYTES; i++) begin
            checkData("memory after DMA", memModel.mem[busAddr_t'(dst + i)],
                      shadowMem[busAddr_t'(dst + i)]);
        end

        repeat (2) @(posedge CLK_n);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/busMemoryModel.sv
// Testbench memory and I/O space that answers the Z80 strobes and inserts random wait states
`default_nettype none

`include "z80Bus_cfg.svh"

module busMemoryModel (
    input  wire                      CLK_n,
    input  wire                      Reset_s,
    input  wire                      waitEnable_i,
    input  wire z80BusPkg::busAddr_t a_i,
    input  wire z80BusPkg::busData_t d_i,
    input  wire                      mreqN_i,
    input  wire                      iorqN_i,
    input  wire                      rdN_i,
    input  wire                      wrN_i,
    input  wire                      rfshN_i,
    output logic                     wait_o,
    output z80BusPkg::busData_t      d_o,
    output logic [31:0]              waitCount_o,
    output logic                     protoErr_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import z80BusPkg::*;

    busData_t    mem [0:65535];
    busData_t    io [0:255];
    logic [31:0] lcgState;
    logic        memCycle;
    logic        ioCycle;
    logic        inWindow;
    logic        windowDone;
    logic [1:0]  autoLeft;
    logic        strobeClash = 1'b0;
    logic        writeDuringRead = 1'b0;

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Every byte depends on both halves of its address
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = busData_t'(i) ^ busData_t'(i >> 8) ^ 8'h5a;
        end
        for (int i = 0; i < 256; i++) begin
            io[i] = ~busData_t'(i) ^ 8'h3c;
        end
    end

    // Refresh also pulls MREQ low, but it is not a data cycle
    assign memCycle = !mreqN_i && rfshN_i;
    assign ioCycle  = !iorqN_i;

    assign d_o = (!rdN_i && !mreqN_i) ? mem[a_i] :
                 (!rdN_i && !iorqN_i) ? io[a_i[7:0]] : 8'hff;

    // WAIT changes on the rising edge, so the falling edge sample is stable
    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            lcgState <= 32'h8b4c;
            wait_o   <= 1'b1;
        end else begin
            lcgState <= lcgStep(lcgState);
            wait_o   <= !(waitEnable_i && lcgState[17:16] == 2'b00);
        end
    end

    always @(posedge CLK_n) begin
        if (!wrN_i && !mreqN_i) begin
            mem[a_i] <= d_i;
        end else if (!wrN_i && !iorqN_i) begin
            io[a_i[7:0]] <= d_i;
        end
    end

    // The first falling edge that sees the cycle strobe low is the one in T2.
    // A high sample ends the window once the automatic I/O wait is used up
    always @(negedge CLK_n or negedge Reset_s) begin
        logic [1:0] owed;
        if (!Reset_s) begin
            inWindow    <= 1'b0;
            windowDone  <= 1'b0;
            autoLeft    <= 2'd0;
            waitCount_o <= '0;
        end else if (!memCycle && !ioCycle) begin
            inWindow   <= 1'b0;
            windowDone <= 1'b0;
        end else if (!windowDone) begin
            owed = inWindow ? autoLeft : (ioCycle ? 2'(`Z80_IO_WAITS) : 2'd0);
            inWindow <= 1'b1;
            if (!wait_o) begin
                waitCount_o <= waitCount_o + 1;
            end else if (owed != 2'd0) begin
                owed = owed - 2'd1;
            end else begin
                windowDone <= 1'b1;
            end
            autoLeft <= owed;
        end
    end

    always @(posedge CLK_n or negedge CLK_n) begin
        if (!mreqN_i && !iorqN_i) begin
            $display("Bus model saw MREQ and IORQ low at the same time at %0t", $time);
            strobeClash <= 1'b1;
        end
    end

    always @(negedge wrN_i) begin
        if (!rdN_i) begin
            $display("Bus model saw WR fall while RD was low at %0t", $time);
            writeDuringRead <= 1'b1;
        end
    end

    assign protoErr_o = strobeClash || writeDuringRead;

endmodule

`default_nettype wire

//--- logic/z80BusSubsystem.sv
// Top level of the Z80 external bus unit with host port, DMA engine and shared bus strobes
`default_nettype none

module z80BusSubsystem (
    input  wire                        CLK_n,
    input  wire                        Reset_s,
    input  wire                        reqValid_i,
    input  wire z80BusPkg::cycleKind_t reqKind_i,
    input  wire z80BusPkg::busAddr_t   reqAddr_i,
    input  wire z80BusPkg::busData_t   reqWrData_i,
    output logic                       reqReady_o,
    output logic                       rspValid_o,
    output z80BusPkg::busData_t        rspData_o,
    input  wire                        dmaStart_i,
    input  wire z80BusPkg::busAddr_t   dmaSrc_i,
    input  wire z80BusPkg::busAddr_t   dmaDst_i,
    input  wire z80BusPkg::dmaLen_t    dmaLen_i,
    output logic                       dmaBusy_o,
    input  wire                        wait_i,
    input  wire z80BusPkg::busData_t   d_i,
    output z80BusPkg::busAddr_t        a_o,
    output z80BusPkg::busData_t        d_o,
    output logic                       m1N_o,
    output logic                       mreqN_o,
    output logic                       iorqN_o,
    output logic                       rdN_o,
    output logic                       wrN_o,
    output logic                       rfshN_o,
    output logic                       busakN_o
);

    import z80BusPkg::*;

    logic       hostGrant;
    logic       dmaGrant;
    logic       dmaReq;
    cycleKind_t dmaKind;
    busAddr_t   dmaAddr;
    busData_t   dmaWrData;
    logic       cycStart;
    cycleKind_t cycKind;
    busAddr_t   cycAddr;
    busData_t   cycWrData;
    logic       cycIdle;
    tState_t    tState;
    cycleKind_t seqKind;
    rfshCount_t rfshAddr;
    busData_t   rdData;
    logic       cycDone;

    busArbiter arbiter (
        .CLK_n(CLK_n), .Reset_s(Reset_s),
        .hostReq_i(reqValid_i), .hostKind_i(reqKind_i),
        .hostAddr_i(reqAddr_i), .hostWrData_i(reqWrData_i),
        .dmaReq_i(dmaReq), .dmaKind_i(dmaKind),
        .dmaAddr_i(dmaAddr), .dmaWrData_i(dmaWrData),
        .dmaBusy_i(dmaBusy_o), .cycIdle_i(cycIdle),
        .hostGrant_o(hostGrant), .dmaGrant_o(dmaGrant),
        .cycStart_o(cycStart), .cycKind_o(cycKind),
        .cycAddr_o(cycAddr), .cycWrData_o(cycWrData),
        .busakN_o(busakN_o)
    );

    tStateSequencer sequencer (
        .CLK_n(CLK_n), .Reset_s(Reset_s),
        .cycStart_i(cycStart), .cycKind_i(cycKind),
        .cycAddr_i(cycAddr), .cycWrData_i(cycWrData),
        .wait_i(wait_i), .rfshAddr_i(rfshAddr),
        .tState_o(tState), .cycKind_o(seqKind), .cycIdle_o(cycIdle),
        .a_o(a_o), .d_o(d_o)
    );

    busStrobeGen strobeGen (
        .CLK_n(CLK_n), .Reset_s(Reset_s),
        .tState_i(tState), .cycKind_i(seqKind), .d_i(d_i),
        .m1N_o(m1N_o), .mreqN_o(mreqN_o), .iorqN_o(iorqN_o),
        .rdN_o(rdN_o), .wrN_o(wrN_o), .rfshN_o(rfshN_o),
        .rfshAddr_o(rfshAddr), .rdData_o(rdData), .cycDone_o(cycDone)
    );

    dmaBlockMover dmaEngine (
        .CLK_n(CLK_n), .Reset_s(Reset_s),
        .dmaStart_i(dmaStart_i), .dmaSrc_i(dmaSrc_i),
        .dmaDst_i(dmaDst_i), .dmaLen_i(dmaLen_i),
        .dmaGrant_i(dmaGrant), .cycDone_i(cycDone), .rdData_i(rdData),
        .dmaReq_o(dmaReq), .dmaKind_o(dmaKind),
        .dmaAddr_o(dmaAddr), .dmaWrData_o(dmaWrData),
        .dmaBusy_o(dmaBusy_o)
    );

    // The host sees a response only for cycles it owns, BUSAK high means host
    assign reqReady_o = hostGrant;
    assign rspValid_o = cycDone && busakN_o;
    assign rspData_o  = rdData;

endmodule

`default_nettype wire

//--- logic/busArbiter.sv
// Arbiter that hands the cycle sequencer to the host port or the DMA engine between cycles
`default_nettype none

module busArbiter (
    input  wire                        CLK_n,
    input  wire                        Reset_s,
    input  wire                        hostReq_i,
    input  wire z80BusPkg::cycleKind_t hostKind_i,
    input  wire z80BusPkg::busAddr_t   hostAddr_i,
    input  wire z80BusPkg::busData_t   hostWrData_i,
    input  wire                        dmaReq_i,
    input  wire z80BusPkg::cycleKind_t dmaKind_i,
    input  wire z80BusPkg::busAddr_t   dmaAddr_i,
    input  wire z80BusPkg::busData_t   dmaWrData_i,
    input  wire                        dmaBusy_i,
    input  wire                        cycIdle_i,
    output logic                       hostGrant_o,
    output logic                       dmaGrant_o,
    output logic                       cycStart_o,
    output z80BusPkg::cycleKind_t      cycKind_o,
    output z80BusPkg::busAddr_t        cycAddr_o,
    output z80BusPkg::busData_t        cycWrData_o,
    output logic                       busakN_o
);

    import z80BusPkg::*;

    busOwner_t owner;

    // DMA wins a free sequencer; the host also waits out a whole block move
    assign dmaGrant_o  = dmaReq_i && cycIdle_i;
    assign hostGrant_o = hostReq_i && cycIdle_i && (owner == host) && !dmaBusy_i
                         && !dmaReq_i;
    assign cycStart_o  = hostGrant_o || dmaGrant_o;

    assign cycKind_o   = dmaGrant_o ? dmaKind_i : hostKind_i;
    assign cycAddr_o   = dmaGrant_o ? dmaAddr_i : hostAddr_i;
    assign cycWrData_o = dmaGrant_o ? dmaWrData_i : hostWrData_i;

    // Ownership passes to DMA at its first grant and back when the block is done
    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            owner <= host;
        end else if (dmaGrant_o) begin
            owner <= dma;
        end else if (owner == dma && !dmaBusy_i) begin
            owner <= host;
        end
    end

    assign busakN_o = (owner != dma);

endmodule

`default_nettype wire

//--- logic/dmaBlockMover.sv
// Block-move DMA master that copies memory by alternating read and write cycles
`default_nettype none

module dmaBlockMover (
    input  wire                        CLK_n,
    input  wire                        Reset_s,
    input  wire                        dmaStart_i,
    input  wire z80BusPkg::busAddr_t   dmaSrc_i,
    input  wire z80BusPkg::busAddr_t   dmaDst_i,
    input  wire z80BusPkg::dmaLen_t    dmaLen_i,
    input  wire                        dmaGrant_i,
    input  wire                        cycDone_i,
    input  wire z80BusPkg::busData_t   rdData_i,
    output logic                       dmaReq_o,
    output z80BusPkg::cycleKind_t      dmaKind_o,
    output z80BusPkg::busAddr_t        dmaAddr_o,
    output z80BusPkg::busData_t        dmaWrData_o,
    output logic                       dmaBusy_o
);

    import z80BusPkg::*;

    busAddr_t srcPtr;
    busAddr_t dstPtr;
    dmaLen_t  remaining;
    busData_t heldByte;

    logic busy;
    logic writePhase;
    logic reqPending;

    // A done pulse is ours only after our request was granted
    logic ownDone;

    assign ownDone = busy && !reqPending && cycDone_i;

    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            busy       <= 1'b0;
            writePhase <= 1'b0;
            reqPending <= 1'b0;
        end else if (!busy) begin
            // Zero length finishes at once and never touches the bus
            if (dmaStart_i && dmaLen_i != '0) begin
                busy       <= 1'b1;
                writePhase <= 1'b0;
                reqPending <= 1'b1;
            end
        end else if (reqPending) begin
            if (dmaGrant_i) begin
                reqPending <= 1'b0;
            end
        end else if (ownDone) begin
            if (!writePhase) begin
                writePhase <= 1'b1;
                reqPending <= 1'b1;
            end else begin
                writePhase <= 1'b0;
                if (remaining == dmaLen_t'(1)) begin
                    busy <= 1'b0;
                end else begin
                    reqPending <= 1'b1;
                end
            end
        end
    end

    // Pointers advance once a byte has been written
    always_ff @(posedge CLK_n) begin
        if (!busy && dmaStart_i) begin
            srcPtr    <= dmaSrc_i;
            dstPtr    <= dmaDst_i;
            remaining <= dmaLen_i;
        end else if (ownDone) begin
            if (!writePhase) begin
                heldByte <= rdData_i;
            end else begin
                srcPtr    <= srcPtr + 1'b1;
                dstPtr    <= dstPtr + 1'b1;
                remaining <= remaining - 1'b1;
            end
        end
    end

    assign dmaReq_o    = reqPending;
    assign dmaKind_o   = writePhase ? memWrite : memRead;
    assign dmaAddr_o   = writePhase ? dstPtr : srcPtr;
    assign dmaWrData_o = heldByte;
    assign dmaBusy_o   = busy;

endmodule

`default_nettype wire

//--- logic/busStrobeGen.sv
// Z80 bus strobe generator that turns T-state and cycle kind into MREQ, IORQ, RD, WR, M1, RFSH
`default_nettype none

module busStrobeGen (
    input  wire                        CLK_n,
    input  wire                        Reset_s,
    input  wire z80BusPkg::tState_t    tState_i,
    input  wire z80BusPkg::cycleKind_t cycKind_i,
    input  wire z80BusPkg::busData_t   d_i,
    output logic                       m1N_o,
    output logic                       mreqN_o,
    output logic                       iorqN_o,
    output logic                       rdN_o,
    output logic                       wrN_o,
    output logic                       rfshN_o,
    output z80BusPkg::rfshCount_t      rfshAddr_o,
    output z80BusPkg::busData_t        rdData_o,
    output logic                       cycDone_o
);

    import z80BusPkg::*;

    logic isFetch;
    logic isIo;
    logic isMem;
    logic isRead;

    // Strobe requests, all changed on the falling edge
    logic memRq;
    logic ioRq;
    logic rdRq;
    logic wrRq;
    logic rfshRq;

    // IORQ follows its request half a cycle late, on the next rising edge
    logic ioDelay;
    logic ioGate;
    logic fetchDrop;

    rfshCount_t rfshCnt;
    busData_t   opcodeLatch;
    busData_t   dataLatch;

    assign isFetch = (cycKind_i == fetch);
    assign isIo    = (cycKind_i == ioRead) || (cycKind_i == ioWrite);
    assign isMem   = isFetch || (cycKind_i == memRead) || (cycKind_i == memWrite);
    assign isRead  = isFetch || (cycKind_i == memRead) || (cycKind_i == ioRead);

    always_ff @(negedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            memRq  <= 1'b0;
            ioRq   <= 1'b0;
            rdRq   <= 1'b0;
            wrRq   <= 1'b0;
            rfshRq <= 1'b0;
        end else begin
            case (tState_i)
                t1: begin
                    memRq <= isMem;
                    ioRq  <= isIo;
                    rdRq  <= isRead;
                    // I/O write takes WR with IORQ, a memory write waits for T2
                    wrRq  <= (cycKind_i == ioWrite);
                end
                t2: begin
                    if (cycKind_i == memWrite) begin
                        wrRq <= 1'b1;
                    end
                end
                t3: begin
                    memRq <= 1'b0;
                    ioRq  <= 1'b0;
                    rdRq  <= 1'b0;
                    wrRq  <= 1'b0;
                end
                default: ;
            endcase
            // Refresh MREQ spans falling T3 to falling T4 of a fetch
            rfshRq <= isFetch && (tState_i == t3);
        end
    end

    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            ioDelay   <= 1'b0;
            cycDone_o <= 1'b0;
            rfshCnt   <= '0;
        end else begin
            ioDelay <= ioRq;
            // Done follows the last T-state by one cycle
            cycDone_o <= (tState_i == t4) || (tState_i == t3 && !isFetch);
            // One refresh row per fetch, stepped as T4 ends
            if (isFetch && tState_i == t4) begin
                rfshCnt <= rfshCnt + 1'b1;
            end
        end
    end

    // The opcode is taken at the rising edge that opens T3, when RD drops early.
    // Every rising edge in T2 and TW overwrites it, so the last one wins
    always_ff @(posedge CLK_n) begin
        if (isFetch && (tState_i == t2 || tState_i == tw)) begin
            opcodeLatch <= d_i;
        end
    end

    // Plain memory and I/O reads are latched on the falling edge in T3
    always_ff @(negedge CLK_n) begin
        if (tState_i == t3 && !isFetch) begin
            dataLatch <= d_i;
        end
    end

    // In an opcode fetch MREQ and RD leave at the start of T3 instead of its middle
    assign fetchDrop = isFetch && (tState_i == t3);
    assign ioGate    = !ioRq || ioDelay;

    assign mreqN_o = !((memRq && !fetchDrop) || rfshRq);
    assign iorqN_o = !(ioRq && ioDelay);
    assign rdN_o   = !(rdRq && !fetchDrop && ioGate);
    assign wrN_o   = !(wrRq && ioGate);

    // M1 marks the opcode part of a fetch, RFSH its refresh part
    assign m1N_o   = !(isFetch && (tState_i == t1 || tState_i == t2 || tState_i == tw));
    assign rfshN_o = !(isFetch && (tState_i == t3 || tState_i == t4));

    assign rfshAddr_o = rfshCnt;
    assign rdData_o   = isFetch ? opcodeLatch : dataLatch;

endmodule

`default_nettype wire

//--- logic/tStateSequencer.sv
// Machine cycle sequencer that steps T-states, inserts wait states and drives the address bus
`default_nettype none

`include "z80Bus_cfg.svh"

module tStateSequencer (
    input  wire                      CLK_n,
    input  wire                      Reset_s,
    input  wire                      cycStart_i,
    input  wire z80BusPkg::cycleKind_t cycKind_i,
    input  wire z80BusPkg::busAddr_t   cycAddr_i,
    input  wire z80BusPkg::busData_t   cycWrData_i,
    input  wire                      wait_i,
    input  wire z80BusPkg::rfshCount_t rfshAddr_i,
    output z80BusPkg::tState_t       tState_o,
    output z80BusPkg::cycleKind_t    cycKind_o,
    output logic                     cycIdle_o,
    output z80BusPkg::busAddr_t      a_o,
    output z80BusPkg::busData_t      d_o
);

    import z80BusPkg::*;

    tState_t    tState;
    cycleKind_t kindReg;
    busAddr_t   addrReg;
    busData_t   dataReg;

    // Wait states still owed to the current cycle, automatic ones included
    logic [2:0] waitsOwed;
    logic [2:0] nextOwed;
    logic       waitSample;
    logic       rfshSlot;

    // WAIT is sampled half a cycle before the rising edge that decides on TW
    always_ff @(negedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            waitSample <= 1'b1;
        end else begin
            waitSample <= wait_i;
        end
    end

    // A low WAIT sample in T2 or TW adds one more TW on top of what is owed
    assign nextOwed = waitsOwed + {2'b00, ~waitSample};

    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            tState    <= idle;
            kindReg   <= memRead;
            waitsOwed <= '0;
        end else begin
            case (tState)
                idle: begin
                    if (cycStart_i) begin
                        tState  <= t1;
                        kindReg <= cycKind_i;
                        // I/O cycles carry the automatic TW after T2
                        if (cycKind_i == ioRead || cycKind_i == ioWrite) begin
                            waitsOwed <= 3'(`Z80_IO_WAITS);
                        end else begin
                            waitsOwed <= '0;
                        end
                    end
                end
                t1: tState <= t2;
                t2, tw: begin
                    if (nextOwed != '0) begin
                        tState    <= tw;
                        waitsOwed <= nextOwed - 3'd1;
                    end else begin
                        tState <= t3;
                    end
                end
                // Only the opcode fetch has a T4, used for refresh
                t3: tState <= (kindReg == fetch) ? t4 : idle;
                default: tState <= idle;
            endcase
        end
    end

    // Address and write data are held for the whole cycle
    always_ff @(posedge CLK_n) begin
        if (tState == idle && cycStart_i) begin
            addrReg <= cycAddr_i;
            dataReg <= cycWrData_i;
        end
    end

    // T3 and T4 of a fetch belong to refresh, so the refresh row replaces the address
    assign rfshSlot = (kindReg == fetch) && (tState == t3 || tState == t4);
    assign a_o = rfshSlot ?
        busAddr_t'({{(`Z80_ADDR_W - `Z80_RFSH_W){1'b0}}, rfshAddr_i}) : addrReg;

    assign d_o       = dataReg;
    assign tState_o  = tState;
    assign cycKind_o = kindReg;
    assign cycIdle_o = (tState == idle);

endmodule

`default_nettype wire

//--- logic/z80BusPkg.sv
// Shared bus types and state encodings, imported by every block of the bus unit
`default_nettype none

`include "z80Bus_cfg.svh"

package z80BusPkg;

    // Memory or I/O address as it appears on A
    typedef logic [`Z80_ADDR_W-1:0] busAddr_t;

    // One byte on the data bus
    typedef logic [`Z80_DATA_W-1:0] busData_t;

    // Refresh row, driven on the low address bits during refresh
    typedef logic [`Z80_RFSH_W-1:0] rfshCount_t;

    // Number of bytes in a block move
    typedef logic [`DMA_LEN_W-1:0] dmaLen_t;

    // Kind of machine cycle that the sequencer runs
    typedef enum logic [2:0] {
        fetch,
        memRead,
        memWrite,
        ioRead,
        ioWrite
    } cycleKind_t;

    // T-state of the current machine cycle, idle between cycles
    typedef enum logic [2:0] {
        idle,
        t1,
        t2,
        tw,
        t3,
        t4
    } tState_t;

    // Master that currently owns the cycle sequencer
    typedef enum logic {
        host,
        dma
    } busOwner_t;

endpackage

`default_nettype wire

//--- logic/z80Bus_cfg.svh
// Bus widths and timing constants for the Z80 bus unit, included by the package and the sequencer
`ifndef Z80_BUS_CFG_SVH
`define Z80_BUS_CFG_SVH

// Address bus width of the Z80 memory and I/O space
`define Z80_ADDR_W 16

// Data bus width
`define Z80_DATA_W 8

// Automatic wait states the Z80 adds to every I/O cycle after T2
`define Z80_IO_WAITS 1

// Width of the refresh row counter placed on the low address bits
`define Z80_RFSH_W 7

// Byte count width of a DMA block move
`define DMA_LEN_W 16

`endif
